// ==== hdl/cnn_pkg.sv ====
package cnn_pkg;

  localparam int DATA_BITS   = 32;
  localparam int PIX_BITS    = 8;
  localparam int KERNEL      = 5;
  localparam int KERNEL_TAPS = KERNEL * KERNEL;
  localparam int NUM_FILTERS = 8;
  localparam int TILE_COLS   = 8;
  localparam int TILE_ROWS   = 6;
  localparam int OUT_ROWS    = 2;
  localparam int OUT_COLS    = 4;
  localparam int IF_WORDS    = 12; // 48 pixels, 4 per word
  localparam int W_WORDS     = 50; // 200 weights
  localparam int OUT_WORDS   = 4;

  typedef logic        [PIX_BITS-1:0] pixel_t;
  typedef logic signed [PIX_BITS-1:0] weight_t;
  typedef logic signed [31:0]         acc_t;

  // tap t sits at kernel row t/5, column t%5
  typedef pixel_t  [KERNEL_TAPS-1:0] window_t;
  typedef weight_t [KERNEL_TAPS-1:0] kernel_t;

  typedef struct packed {
    logic                 en;
    logic [3:0]           we;
    logic [DATA_BITS-1:0] addr;
    logic [DATA_BITS-1:0] din;
  } bram_req_t;

  typedef struct packed {
    logic       valid;
    logic [5:0] word_idx;
  } load_t;

  typedef struct packed {
    logic       valid;
    logic       row;
    logic [1:0] col;
  } win_sel_t;

  typedef enum logic [1:0] {
    idle,
    load,
    window,
    wait_done
  } ctrl_state_t;

endpackage

// ==== hdl/conv_ctrl.sv ====
`timescale 1ns/1ps

module conv_ctrl
  import cnn_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      i_start,
  input  logic      i_done,
  output bram_req_t o_if_req,
  output bram_req_t o_w_req,
  output load_t     o_if_load,
  output load_t     o_w_load,
  output win_sel_t  o_win_sel
);

  localparam int NUM_WIN = OUT_ROWS * OUT_COLS;

  ctrl_state_t state;
  logic [5:0]  cnt; // word address in load, window index in window

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= idle;
      cnt   <= '0;
    end else begin
      case (state)
        idle: begin
          cnt <= '0;
          if (i_start) begin
            state <= load;
          end
        end
        load: begin
          if (cnt == 6'(W_WORDS - 1)) begin
            state <= window;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 6'd1;
          end
        end
        window: begin
          if (cnt == 6'(NUM_WIN - 1)) begin
            state <= wait_done;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 6'd1;
          end
        end
        wait_done: begin
          if (i_done) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // weights take all 50 load cycles, pixels only the first 12
  always_comb begin
    o_w_req       = '0;
    o_w_req.en    = (state == load);
    o_w_req.addr  = DATA_BITS'(cnt);
    o_if_req      = '0;
    o_if_req.en   = (state == load) && (cnt < 6'(IF_WORDS));
    o_if_req.addr = DATA_BITS'(cnt);
  end

  // strobes trail the address by the memory read latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_if_load <= '0;
      o_w_load  <= '0;
    end else begin
      o_if_load.valid    <= o_if_req.en;
      o_if_load.word_idx <= cnt;
      o_w_load.valid     <= o_w_req.en;
      o_w_load.word_idx  <= cnt;
    end
  end

  // window order (0,0) (0,1) (1,0) (1,1), then the right 2x2 block
  always_comb begin
    o_win_sel.valid = (state == window);
    o_win_sel.row   = cnt[1];
    o_win_sel.col   = {cnt[2], cnt[0]};
  end

endmodule

// ==== hdl/feature_cache.sv ====
`timescale 1ns/1ps

module feature_cache
  import cnn_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  load_t                i_load,
  input  logic [DATA_BITS-1:0] i_dout,
  input  win_sel_t             i_win_sel,
  output window_t              o_window,
  output logic                 o_win_valid
);

  localparam int BYTES_PER_WORD = DATA_BITS / PIX_BITS;

  pixel_t pix [TILE_ROWS*TILE_COLS]; // pixel (r,c) at 8r+c

  // byte 0 of a word is the msb lane
  always_ff @(posedge clk) begin
    if (i_load.valid) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        pix[BYTES_PER_WORD*i_load.word_idx + b] <= i_dout[DATA_BITS-1-PIX_BITS*b -: PIX_BITS];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_win_sel.valid) begin
      for (int kr = 0; kr < KERNEL; kr++) begin
        for (int kc = 0; kc < KERNEL; kc++) begin
          o_window[KERNEL*kr + kc] <=
            pix[TILE_COLS*(kr + i_win_sel.row) + kc + i_win_sel.col];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_win_valid <= 1'b0;
    end else begin
      o_win_valid <= i_win_sel.valid;
    end
  end

endmodule

// ==== hdl/weight_cache.sv ====
`timescale 1ns/1ps

module weight_cache
  import cnn_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  load_t                     i_load,
  input  logic [DATA_BITS-1:0]      i_dout,
  output kernel_t [NUM_FILTERS-1:0] o_kernels
);

  localparam int BYTES_PER_WORD = DATA_BITS / PIX_BITS;

  weight_t w_mem [NUM_FILTERS*KERNEL_TAPS]; // tap t of filter f at 25f+t

  // kernels read as zero until the first load
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_FILTERS*KERNEL_TAPS; i++) begin
        w_mem[i] <= '0;
      end
    end else if (i_load.valid) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        w_mem[BYTES_PER_WORD*i_load.word_idx + b] <=
          weight_t'(i_dout[DATA_BITS-1-PIX_BITS*b -: PIX_BITS]);
      end
    end
  end

  always_comb begin
    for (int f = 0; f < NUM_FILTERS; f++) begin
      for (int t = 0; t < KERNEL_TAPS; t++) begin
        o_kernels[f][t] = w_mem[KERNEL_TAPS*f + t];
      end
    end
  end

endmodule

// ==== hdl/conv_pe.sv ====
`timescale 1ns/1ps

module conv_pe
  import cnn_pkg::*;
#(
  parameter int QUANT_SHIFT = 4
) (
  input  logic    clk,
  input  logic    rst,
  input  window_t i_window,
  input  kernel_t i_kernel,
  input  logic    i_valid,
  output pixel_t  o_result,
  output logic    o_valid
);

  localparam acc_t PIX_MAX = acc_t'(2**PIX_BITS - 1);

  acc_t   sum;
  acc_t   scaled;
  pixel_t quant;

  // pixels are unsigned, so zero-extend before the signed multiply
  always_comb begin
    sum = '0;
    for (int t = 0; t < KERNEL_TAPS; t++) begin
      sum = sum + acc_t'(signed'({1'b0, i_window[t]})) * acc_t'(signed'(i_kernel[t]));
    end
  end

  assign scaled = sum >>> QUANT_SHIFT;

  always_comb begin
    if (sum < 0) begin
      quant = '0; // relu
    end else if (scaled > PIX_MAX) begin
      quant = PIX_MAX[PIX_BITS-1:0]; // saturate
    end else begin
      quant = scaled[PIX_BITS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_result <= quant;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

endmodule

// ==== hdl/pool_writer.sv ====
`timescale 1ns/1ps

module pool_writer
  import cnn_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  pixel_t [NUM_FILTERS-1:0] i_results,
  input  logic                     i_valid,
  output bram_req_t                o_temp_req,
  output logic                     o_done
);

  localparam int NUM_WIN        = OUT_ROWS * OUT_COLS;
  localparam int POOL_GROUPS    = NUM_WIN / 4;
  localparam int BUF_BYTES      = NUM_FILTERS * POOL_GROUPS;
  localparam int BYTES_PER_WORD = DATA_BITS / PIX_BITS;
  localparam int CNT_BITS       = $clog2(NUM_WIN);
  localparam int IDX_BITS       = $clog2(OUT_WORDS);

  logic [CNT_BITS-1:0]      res_cnt; // [1:0] position in group, [2] group
  pixel_t [NUM_FILTERS-1:0] run_max;
  pixel_t [NUM_FILTERS-1:0] cur_max;
  pixel_t [BUF_BYTES-1:0]   pool_buf; // filter f, group g at 2f+g
  logic                     wr_active;
  logic [IDX_BITS-1:0]      wr_idx;
  logic [DATA_BITS-1:0]     wr_word;

  // first result of a group restarts the max
  always_comb begin
    for (int f = 0; f < NUM_FILTERS; f++) begin
      if (res_cnt[1:0] == 2'd0 || i_results[f] > run_max[f]) begin
        cur_max[f] = i_results[f];
      end else begin
        cur_max[f] = run_max[f];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      run_max <= cur_max;
      if (res_cnt[1:0] == 2'd3) begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
          pool_buf[POOL_GROUPS*f + res_cnt[2]] <= cur_max[f];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_cnt   <= '0;
      wr_active <= 1'b0;
      wr_idx    <= '0;
      o_done    <= 1'b0;
    end else begin
      o_done <= wr_active && (wr_idx == IDX_BITS'(OUT_WORDS - 1));
      if (i_valid) begin
        res_cnt <= res_cnt + 1'b1; // wraps after the last window
      end
      if (i_valid && res_cnt == CNT_BITS'(NUM_WIN - 1)) begin
        wr_active <= 1'b1;
        wr_idx    <= '0;
      end else if (wr_active) begin
        wr_idx <= wr_idx + 1'b1;
        if (wr_idx == IDX_BITS'(OUT_WORDS - 1)) begin
          wr_active <= 1'b0;
        end
      end
    end
  end

  // lowest buffer index goes to the top byte
  always_comb begin
    for (int b = 0; b < BYTES_PER_WORD; b++) begin
      wr_word[DATA_BITS-1-PIX_BITS*b -: PIX_BITS] = pool_buf[BYTES_PER_WORD*wr_idx + b];
    end
  end

  always_comb begin
    o_temp_req      = '0;
    o_temp_req.en   = wr_active;
    o_temp_req.we   = {4{wr_active}};
    o_temp_req.addr = DATA_BITS'(wr_idx);
    o_temp_req.din  = wr_word;
  end

endmodule

// ==== hdl/cnn_top.sv ====
`timescale 1ns/1ps

module cnn_top
  import cnn_pkg::*;
#(
  parameter int QUANT_SHIFT = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_start,
  output logic                 o_done,
  output bram_req_t            o_if_req,
  output bram_req_t            o_w_req,
  input  logic [DATA_BITS-1:0] i_if_dout,
  input  logic [DATA_BITS-1:0] i_w_dout,
  output bram_req_t            o_temp_req
);

  load_t                     if_load;
  load_t                     w_load;
  win_sel_t                  win_sel;
  window_t                   pix_window;
  logic                      win_valid;
  kernel_t [NUM_FILTERS-1:0] kernels;
  pixel_t  [NUM_FILTERS-1:0] results;
  logic                      res_valid;

  conv_ctrl ctrl_i (
    .clk       (clk),
    .rst       (rst),
    .i_start   (i_start),
    .i_done    (o_done),
    .o_if_req  (o_if_req),
    .o_w_req   (o_w_req),
    .o_if_load (if_load),
    .o_w_load  (w_load),
    .o_win_sel (win_sel)
  );

  feature_cache fcache_i (
    .clk         (clk),
    .rst         (rst),
    .i_load      (if_load),
    .i_dout      (i_if_dout),
    .i_win_sel   (win_sel),
    .o_window    (pix_window),
    .o_win_valid (win_valid)
  );

  weight_cache wcache_i (
    .clk       (clk),
    .rst       (rst),
    .i_load    (w_load),
    .i_dout    (i_w_dout),
    .o_kernels (kernels)
  );

  // one PE per filter, all fed the same window
  for (genvar f = 0; f < NUM_FILTERS; f++) begin : g_pe
    if (f == 0) begin : g_lead
      conv_pe #(.QUANT_SHIFT(QUANT_SHIFT)) pe_i (
        .clk      (clk),
        .rst      (rst),
        .i_window (pix_window),
        .i_kernel (kernels[f]),
        .i_valid  (win_valid),
        .o_result (results[f]),
        .o_valid  (res_valid) // all PEs are in lockstep
      );
    end else begin : g_rest
      conv_pe #(.QUANT_SHIFT(QUANT_SHIFT)) pe_i (
        .clk      (clk),
        .rst      (rst),
        .i_window (pix_window),
        .i_kernel (kernels[f]),
        .i_valid  (win_valid),
        .o_result (results[f]),
        .o_valid  ()
      );
    end
  end

  pool_writer pool_i (
    .clk        (clk),
    .rst        (rst),
    .i_results  (results),
    .i_valid    (res_valid),
    .o_temp_req (o_temp_req),
    .o_done     (o_done)
  );

endmodule

// ==== verification/cnn_props.sv ====
`timescale 1ns/1ps

module cnn_props
  import cnn_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      i_done,
  input bram_req_t i_if_req,
  input bram_req_t i_w_req,
  input bram_req_t i_temp_req
);

  // done is a single-cycle pulse
  done_pulse_a: assert property (@(posedge clk) disable iff (rst) i_done |=> !i_done)
    else $error("o_done stayed high for more than one cycle");

  // full-word writes only, and never without en
  temp_we_a: assert property (@(posedge clk) disable iff (rst)
    (i_temp_req.en && i_temp_req.we == 4'hf) || i_temp_req.we == 4'h0)
    else $error("temp write enable is partial or set without en");

  read_only_a: assert property (@(posedge clk) disable iff (rst)
    i_if_req.we == 4'h0 && i_w_req.we == 4'h0)
    else $error("write enable seen on a read-only memory");

endmodule

bind cnn_top cnn_props props_i (
  .clk        (clk),
  .rst        (rst),
  .i_done     (o_done),
  .i_if_req   (o_if_req),
  .i_w_req    (o_w_req),
  .i_temp_req (o_temp_req)
);

// ==== verification/cnn_tb.sv ====
`timescale 1ns/1ps

module cnn_tb
  import cnn_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int QUANT_SHIFT  = 4;
  localparam int RUN_CYCLES   = 200; // generous bound on one start-to-done run
  localparam int NUM_RUNS     = 5;
  localparam int TIMEOUT_NS   = NUM_RUNS * RUN_CYCLES * CLK_PERIOD;

  logic      clk;
  logic      rst;
  logic      i_start;
  logic      done;
  bram_req_t if_req;
  bram_req_t w_req;
  bram_req_t temp_req;
  logic [DATA_BITS-1:0] if_dout = '0;
  logic [DATA_BITS-1:0] w_dout  = '0;

  logic [DATA_BITS-1:0] if_mem [IF_WORDS];
  logic [DATA_BITS-1:0] w_mem [W_WORDS];
  logic [DATA_BITS-1:0] exp_words [OUT_WORDS];
  logic [DATA_BITS-1:0] wr_addr_log [$];
  logic [DATA_BITS-1:0] wr_data_log [$];
  int done_count = 0;

  cnn_top #(.QUANT_SHIFT(QUANT_SHIFT)) dut_i (
    .clk        (clk),
    .rst        (rst),
    .i_start    (i_start),
    .o_done     (done),
    .o_if_req   (if_req),
    .o_w_req    (w_req),
    .i_if_dout  (if_dout),
    .i_w_dout   (w_dout),
    .o_temp_req (temp_req)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // synchronous read memories, one cycle latency
  always @(posedge clk) begin
    if (if_req.en) begin
      check_value("feature read address in range", 32'(if_req.addr < IF_WORDS), 32'd1);
      if_dout <= if_mem[if_req.addr[3:0]];
    end
    if (w_req.en) begin
      check_value("weight read address in range", 32'(w_req.addr < W_WORDS), 32'd1);
      w_dout <= w_mem[w_req.addr[5:0]];
    end
  end

  // temp memory writes and done pulses are logged
  always @(posedge clk) begin
    if (temp_req.en) begin
      wr_addr_log.push_back(temp_req.addr);
      wr_data_log.push_back(temp_req.din);
    end
    if (done) begin
      done_count <= done_count + 1;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // byte 0 of a word sits in bits 31:24
  function automatic int pixel_at(int r, int c);
    int idx;
    idx = TILE_COLS * r + c;
    return int'(if_mem[idx / 4][31 - 8 * (idx % 4) -: 8]);
  endfunction

  function automatic int weight_at(int f, int t);
    int         idx;
    logic [7:0] b;
    idx = KERNEL_TAPS * f + t;
    b   = w_mem[idx / 4][31 - 8 * (idx % 4) -: 8];
    return int'($signed(b));
  endfunction

  task automatic set_pixel(int r, int c, logic [7:0] val);
    int idx;
    idx = TILE_COLS * r + c;
    if_mem[idx / 4][31 - 8 * (idx % 4) -: 8] = val;
  endtask

  task automatic set_weight(int f, int t, logic [7:0] val);
    int idx;
    idx = KERNEL_TAPS * f + t;
    w_mem[idx / 4][31 - 8 * (idx % 4) -: 8] = val;
  endtask

  // conv, relu, shift, clamp for one output position
  function automatic int conv_ref(int f, int r, int c);
    int sum;
    int q;
    sum = 0;
    for (int kr = 0; kr < KERNEL; kr++) begin
      for (int kc = 0; kc < KERNEL; kc++) begin
        sum += pixel_at(r + kr, c + kc) * weight_at(f, KERNEL * kr + kc);
      end
    end
    if (sum < 0) begin
      return 0;
    end
    q = sum >>> QUANT_SHIFT;
    return (q > 255) ? 255 : q;
  endfunction

  // pool group g is the 2x2 block at columns 2g and 2g+1
  task automatic build_expected();
    logic [7:0] pooled [NUM_FILTERS * 2];
    int best;
    int v;
    for (int f = 0; f < NUM_FILTERS; f++) begin
      for (int g = 0; g < 2; g++) begin
        best = 0;
        for (int r = 0; r < OUT_ROWS; r++) begin
          for (int c = 2 * g; c < 2 * g + 2; c++) begin
            v = conv_ref(f, r, c);
            if (v > best) best = v;
          end
        end
        pooled[2 * f + g] = 8'(best);
      end
    end
    for (int w = 0; w < OUT_WORDS; w++) begin
      exp_words[w] = {pooled[4*w], pooled[4*w+1], pooled[4*w+2], pooled[4*w+3]};
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < IF_WORDS; i++) if_mem[i] = $urandom();
    for (int i = 0; i < W_WORDS; i++) w_mem[i] = $urandom();
  endtask

  task automatic start_pulse();
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
  endtask

  task automatic wait_for_done(int done_base);
    while (done_count == done_base) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic check_run(int wr_base, int done_base);
    check_value("temp write count", 32'(wr_addr_log.size() - wr_base), 32'(OUT_WORDS));
    check_value("done pulses", 32'(done_count - done_base), 32'd1);
    for (int w = 0; w < OUT_WORDS; w++) begin
      check_value($sformatf("temp addr of write %0d", w), wr_addr_log[wr_base + w], 32'(w));
      check_value($sformatf("temp word %0d", w), wr_data_log[wr_base + w], exp_words[w]);
    end
  endtask

  task automatic run_and_check(output int wr_base);
    int done_base;
    build_expected();
    wr_base   = wr_addr_log.size();
    done_base = done_count;
    start_pulse();
    wait_for_done(done_base);
    check_run(wr_base, done_base);
  endtask

  task automatic test_random();
    int base;
    fill_random();
    run_and_check(base);
  endtask

  task automatic test_relu();
    int base;
    for (int i = 0; i < IF_WORDS; i++) if_mem[i] = $urandom() | 32'h01010101;
    for (int i = 0; i < W_WORDS; i++) w_mem[i] = $urandom() | 32'h80808080; // all negative
    run_and_check(base);
    for (int w = 0; w < OUT_WORDS; w++) begin
      check_value($sformatf("relu word %0d", w), wr_data_log[base + w], 32'h0);
    end
  endtask

  task automatic test_saturation();
    int base;
    for (int i = 0; i < IF_WORDS; i++) if_mem[i] = 32'hffffffff;
    for (int i = 0; i < W_WORDS; i++) w_mem[i] = 32'h7f7f7f7f;
    run_and_check(base);
    for (int w = 0; w < OUT_WORDS; w++) begin
      check_value($sformatf("saturated word %0d", w), wr_data_log[base + w], 32'hffffffff);
    end
  endtask

  // filter 0 passes the top-left pixel of each window through unchanged
  // row maxima differ from block maxima, so a row-major order would show
  task automatic test_pool_order();
    int base;
    fill_random();
    for (int t = 0; t < KERNEL_TAPS; t++) set_weight(0, t, 8'd0);
    set_weight(0, 0, 8'd16);
    set_pixel(0, 0, 8'd40);
    set_pixel(0, 1, 8'd90);
    set_pixel(1, 0, 8'd70);
    set_pixel(1, 1, 8'd20);
    set_pixel(0, 2, 8'd150);
    set_pixel(0, 3, 8'd5);
    set_pixel(1, 2, 8'd30);
    set_pixel(1, 3, 8'd100);
    run_and_check(base);
    check_value("filter 0 pool group 0", 32'(wr_data_log[base][31:24]), 32'd90);
    check_value("filter 0 pool group 1", 32'(wr_data_log[base][23:16]), 32'd150);
  endtask

  task automatic test_busy_start();
    int wr_base;
    int done_base;
    fill_random();
    build_expected();
    wr_base   = wr_addr_log.size();
    done_base = done_count;
    start_pulse();
    repeat (10) @(posedge clk);
    start_pulse(); // lands in the load phase
    wait_for_done(done_base);
    repeat (RUN_CYCLES / 2) @(posedge clk); // room for a spurious second run
    check_run(wr_base, done_base);
    fill_random();
    run_and_check(wr_base);
  endtask

  task automatic test_reset_mid_run();
    int wr_base;
    int done_base;
    fill_random();
    wr_base   = wr_addr_log.size();
    done_base = done_count;
    start_pulse();
    repeat (30) @(posedge clk);
    rst <= 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("enables during reset", 32'({if_req.en, if_req.we, w_req.en, w_req.we,
                  temp_req.en, temp_req.we, done}), 32'h0);
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("enables after reset", 32'({if_req.en, if_req.we, w_req.en, w_req.we,
                temp_req.en, temp_req.we, done}), 32'h0);
    check_value("writes of aborted run", 32'(wr_addr_log.size() - wr_base), 32'd0);
    check_value("done of aborted run", 32'(done_count - done_base), 32'd0);
    fill_random();
    run_and_check(wr_base);
  endtask

  initial begin
    void'($urandom(32'hecb35690));
    rst     = 1'b1;
    i_start = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_random();
    test_relu();
    test_saturation();
    test_pool_order();
    test_busy_start();
    test_reset_mid_run();
    $display("All tests passed");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== vlog.f ====
hdl/cnn_pkg.sv
hdl/conv_ctrl.sv
hdl/feature_cache.sv
hdl/weight_cache.sv
hdl/conv_pe.sv
hdl/pool_writer.sv
hdl/cnn_top.sv
verification/cnn_props.sv
verification/cnn_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the cnn testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module cnn_tb -f vlog.f

# the simulator exits nonzero on $fatal, so keep its output for the search below
out=$(./obj_dir/Vcnn_tb 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "All tests passed"
